// ==== hw/cpu_config.svh ====
/* pipeline cpu configuration */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction memory depth in words.
`define CPU_IMEM_WORDS 256

// data memory depth in words.
`define CPU_DMEM_WORDS 256

// first fetch address after reset.
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== hw/cpu_pkg.sv ====
/* cpu types and instruction codes */
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  func_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [1:0]  wb_sel_t;

	localparam wb_sel_t wb_alu  = 2'd0;
	localparam wb_sel_t wb_load = 2'd1;
	localparam wb_sel_t wb_link = 2'd2;

	localparam opcode_t op_rtype = 6'h00;
	localparam opcode_t op_j     = 6'h02;
	localparam opcode_t op_jal   = 6'h03;
	localparam opcode_t op_beq   = 6'h04;
	localparam opcode_t op_bne   = 6'h05;
	localparam opcode_t op_addiu = 6'h09;
	localparam opcode_t op_slti  = 6'h0a;
	localparam opcode_t op_andi  = 6'h0c;
	localparam opcode_t op_ori   = 6'h0d;
	localparam opcode_t op_lui   = 6'h0f;
	localparam opcode_t op_lw    = 6'h23;
	localparam opcode_t op_sw    = 6'h2b;

	// r-type function field.
	localparam func_t fn_sll  = 6'h00;
	localparam func_t fn_srl  = 6'h02;
	localparam func_t fn_jr   = 6'h08;
	localparam func_t fn_jalr = 6'h09;
	localparam func_t fn_addu = 6'h21;
	localparam func_t fn_subu = 6'h23;
	localparam func_t fn_and  = 6'h24;
	localparam func_t fn_or   = 6'h25;
	localparam func_t fn_xor  = 6'h26;
	localparam func_t fn_slt  = 6'h2a;

endpackage

// ==== hw/cpu_fetch.sv ====
/* instruction fetch stage */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_fetch (
	input  logic           clk,
	input  logic           rst,
	input  logic           imem_we,
	input  cpu_pkg::word_t imem_addr,
	input  cpu_pkg::word_t imem_wdata,
	input  logic           c_b,
	input  cpu_pkg::word_t baddr,
	input  logic           c_j,
	input  cpu_pkg::word_t jaddr,
	output cpu_pkg::word_t if_pc,
	output cpu_pkg::word_t if_inst
);
	localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);

	cpu_pkg::word_t imem [`CPU_IMEM_WORDS];
	cpu_pkg::word_t pc;
	cpu_pkg::word_t pc_next;

	// redirect from decode takes effect on the delay slot edge.
	always_comb begin
		if (c_b) begin
			pc_next = baddr;
		end else if (c_j) begin
			pc_next = jaddr;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	// program load only while held in reset.
	always_ff @(posedge clk) begin
		if (rst && imem_we) begin
			imem[imem_addr[IMEM_AW-1:0]] <= imem_wdata; // word index.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= `CPU_RESET_PC;
			if_pc   <= '0;
			if_inst <= '0; // nop.
		end else begin
			pc      <= pc_next;
			if_pc   <= pc;
			if_inst <= imem[pc[IMEM_AW+1:2]];
		end
	end

endmodule

// ==== hw/cpu_id.sv ====
/* instruction decode stage */
`timescale 1ns/1ps

module cpu_id (
	input  logic                clk,
	input  logic                rst,
	input  cpu_pkg::word_t      if_pc,
	input  cpu_pkg::word_t      if_inst,
	input  logic                wb_rfw,
	input  cpu_pkg::reg_addr_t  wb_rf_waddr,
	input  cpu_pkg::word_t      wb_rf_wdata,
	output cpu_pkg::word_t      p_rfa,
	output cpu_pkg::word_t      p_rfb,
	output cpu_pkg::word_t      p_rfbse,
	output cpu_pkg::shamt_t     p_shamt,
	output cpu_pkg::func_t      p_func,
	output cpu_pkg::reg_addr_t  p_rf_waddr,
	output cpu_pkg::word_t      p_jalra,
	output logic                p_c_rfw,
	output cpu_pkg::wb_sel_t    p_c_wbsource,
	output logic                p_c_drw,
	output cpu_pkg::opcode_t    p_alucontrol,
	output logic                c_b,
	output cpu_pkg::word_t      baddr,
	output logic                c_j,
	output cpu_pkg::word_t      jaddr
);
	cpu_pkg::word_t rf [31:1];

	cpu_pkg::opcode_t   opcode;
	cpu_pkg::reg_addr_t rs;
	cpu_pkg::reg_addr_t rt;
	cpu_pkg::reg_addr_t rd;
	cpu_pkg::shamt_t    shamt;
	cpu_pkg::func_t     func;
	logic [15:0]        imm;
	logic [25:0]        index;

	cpu_pkg::word_t     rs_val;
	cpu_pkg::word_t     rt_val;
	cpu_pkg::word_t     imm_se;
	cpu_pkg::word_t     imm_ze;
	cpu_pkg::word_t     ext_imm;
	cpu_pkg::word_t     rfbse;
	cpu_pkg::word_t     pc_plus4;
	cpu_pkg::reg_addr_t dest;
	cpu_pkg::wb_sel_t   c_wbsource;
	logic               is_rtype;
	logic               is_jr;
	logic               is_jalr;
	logic               c_rfw;
	logic               c_drw;

	assign opcode = if_inst[31:26];
	assign rs     = if_inst[25:21];
	assign rt     = if_inst[20:16];
	assign rd     = if_inst[15:11];
	assign shamt  = if_inst[10:6];
	assign func   = if_inst[5:0];
	assign imm    = if_inst[15:0];
	assign index  = if_inst[25:0];

	// r0 is hardwired to zero.
	assign rs_val = (rs == 5'd0) ? '0 : rf[rs];
	assign rt_val = (rt == 5'd0) ? '0 : rf[rt];

	assign is_rtype = opcode == cpu_pkg::op_rtype;
	assign is_jr    = is_rtype && func == cpu_pkg::fn_jr;
	assign is_jalr  = is_rtype && func == cpu_pkg::fn_jalr;

	assign c_rfw = !(opcode == cpu_pkg::op_sw || opcode == cpu_pkg::op_beq ||
		opcode == cpu_pkg::op_bne || opcode == cpu_pkg::op_j || is_jr);
	assign c_drw = opcode == cpu_pkg::op_sw;

	always_comb begin
		if (opcode == cpu_pkg::op_lw) begin
			c_wbsource = cpu_pkg::wb_load;
		end else if (opcode == cpu_pkg::op_jal || is_jalr) begin
			c_wbsource = cpu_pkg::wb_link;
		end else begin
			c_wbsource = cpu_pkg::wb_alu;
		end
	end

	always_comb begin
		if (is_rtype) begin
			dest = rd;
		end else if (opcode == cpu_pkg::op_jal) begin
			dest = 5'd31;
		end else begin
			dest = rt;
		end
	end

	assign imm_se  = {{16{imm[15]}}, imm};
	assign imm_ze  = {16'h0000, imm};
	assign ext_imm = (opcode == cpu_pkg::op_andi || opcode == cpu_pkg::op_ori) ? imm_ze : imm_se;
	assign rfbse   = is_rtype ? rt_val : ext_imm;

	// branch and jump resolution.
	assign pc_plus4 = if_pc + 32'd4;
	assign baddr    = {imm_se[29:0], 2'b00} + pc_plus4;
	assign c_b      = (opcode == cpu_pkg::op_beq && rs_val == rt_val) ||
		(opcode == cpu_pkg::op_bne && rs_val != rt_val);
	assign c_j      = opcode == cpu_pkg::op_j || opcode == cpu_pkg::op_jal || is_jr || is_jalr;
	assign jaddr    = (opcode == cpu_pkg::op_j || opcode == cpu_pkg::op_jal) ?
		{pc_plus4[31:28], index, 2'b00} : rs_val;

	// write lands on the edge, same cycle reads get the old value.
	always_ff @(posedge clk) begin
		if (wb_rfw && wb_rf_waddr != 5'd0) begin
			rf[wb_rf_waddr] <= wb_rf_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			p_rfa        <= '0;
			p_rfb        <= '0;
			p_rfbse      <= '0;
			p_shamt      <= '0;
			p_func       <= '0;
			p_rf_waddr   <= '0;
			p_jalra      <= '0;
			p_c_rfw      <= 1'b0;
			p_c_wbsource <= cpu_pkg::wb_alu;
			p_c_drw      <= 1'b0;
			p_alucontrol <= cpu_pkg::op_rtype;
		end else begin
			p_rfa        <= rs_val;
			p_rfb        <= rt_val;
			p_rfbse      <= rfbse;
			p_shamt      <= shamt;
			p_func       <= func;
			p_rf_waddr   <= dest;
			p_jalra      <= if_pc + 32'd8; // past the delay slot.
			p_c_rfw      <= c_rfw;
			p_c_wbsource <= c_wbsource;
			p_c_drw      <= c_drw;
			p_alucontrol <= opcode;
		end
	end

endmodule

// ==== hw/cpu_ex.sv ====
/* execute stage */
`timescale 1ns/1ps

module cpu_ex (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::word_t     p_rfa,
	input  cpu_pkg::word_t     p_rfb,
	input  cpu_pkg::word_t     p_rfbse,
	input  cpu_pkg::shamt_t    p_shamt,
	input  cpu_pkg::func_t     p_func,
	input  cpu_pkg::opcode_t   p_alucontrol,
	input  cpu_pkg::reg_addr_t p_rf_waddr,
	input  cpu_pkg::word_t     p_jalra,
	input  logic               p_c_rfw,
	input  cpu_pkg::wb_sel_t   p_c_wbsource,
	input  logic               p_c_drw,
	output cpu_pkg::word_t     ex_result,
	output cpu_pkg::word_t     ex_store_data,
	output cpu_pkg::reg_addr_t ex_rf_waddr,
	output cpu_pkg::word_t     ex_jalra,
	output logic               ex_c_rfw,
	output cpu_pkg::wb_sel_t   ex_c_wbsource,
	output logic               ex_c_drw
);
	cpu_pkg::word_t result;
	logic           lt_signed;

	assign lt_signed = $signed(p_rfa) < $signed(p_rfbse);

	always_comb begin
		result = '0;
		if (p_alucontrol == cpu_pkg::op_rtype) begin
			case (p_func)
				cpu_pkg::fn_addu: result = p_rfa + p_rfbse;
				cpu_pkg::fn_subu: result = p_rfa - p_rfbse;
				cpu_pkg::fn_and:  result = p_rfa & p_rfbse;
				cpu_pkg::fn_or:   result = p_rfa | p_rfbse;
				cpu_pkg::fn_xor:  result = p_rfa ^ p_rfbse;
				cpu_pkg::fn_slt:  result = {31'd0, lt_signed};
				cpu_pkg::fn_sll:  result = p_rfb << p_shamt;
				cpu_pkg::fn_srl:  result = p_rfb >> p_shamt;
				default:          result = '0; // jr, jalr.
			endcase
		end else begin
			case (p_alucontrol)
				cpu_pkg::op_addiu: result = p_rfa + p_rfbse;
				cpu_pkg::op_lw:    result = p_rfa + p_rfbse; // address.
				cpu_pkg::op_sw:    result = p_rfa + p_rfbse;
				cpu_pkg::op_slti:  result = {31'd0, lt_signed};
				cpu_pkg::op_andi:  result = p_rfa & p_rfbse;
				cpu_pkg::op_ori:   result = p_rfa | p_rfbse;
				cpu_pkg::op_lui:   result = {p_rfbse[15:0], 16'h0000};
				default:           result = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_result     <= '0;
			ex_store_data <= '0;
			ex_rf_waddr   <= '0;
			ex_jalra      <= '0;
			ex_c_rfw      <= 1'b0;
			ex_c_wbsource <= cpu_pkg::wb_alu;
			ex_c_drw      <= 1'b0;
		end else begin
			ex_result     <= result;
			ex_store_data <= p_rfb;
			ex_rf_waddr   <= p_rf_waddr;
			ex_jalra      <= p_jalra;
			ex_c_rfw      <= p_c_rfw;
			ex_c_wbsource <= p_c_wbsource;
			ex_c_drw      <= p_c_drw;
		end
	end

endmodule

// ==== hw/cpu_mem.sv ====
/* memory access and writeback select */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_mem (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::word_t     ex_result,
	input  cpu_pkg::word_t     ex_store_data,
	input  cpu_pkg::word_t     ex_jalra,
	input  cpu_pkg::reg_addr_t ex_rf_waddr,
	input  logic               ex_c_rfw,
	input  cpu_pkg::wb_sel_t   ex_c_wbsource,
	input  logic               ex_c_drw,
	input  cpu_pkg::word_t     dmem_dbg_addr,
	output cpu_pkg::word_t     dmem_dbg_rdata,
	output logic               wb_rfw,
	output cpu_pkg::reg_addr_t wb_rf_waddr,
	output cpu_pkg::word_t     wb_rf_wdata
);
	localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

	cpu_pkg::word_t     dmem [`CPU_DMEM_WORDS];
	logic [DMEM_AW-1:0] dmem_idx;
	cpu_pkg::word_t     load_data;
	cpu_pkg::word_t     wb_data;

	assign dmem_idx       = ex_result[DMEM_AW+1:2]; // drop byte offset.
	assign load_data      = dmem[dmem_idx];
	assign dmem_dbg_rdata = dmem[dmem_dbg_addr[DMEM_AW+1:2]]; // byte address.

	always_ff @(posedge clk) begin
		if (ex_c_drw) begin
			dmem[dmem_idx] <= ex_store_data;
		end
	end

	assign wb_data = (ex_c_wbsource == cpu_pkg::wb_load) ? load_data :
		(ex_c_wbsource == cpu_pkg::wb_link) ? ex_jalra : ex_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_rfw      <= 1'b0;
			wb_rf_waddr <= '0;
			wb_rf_wdata <= '0;
		end else begin
			wb_rfw      <= ex_c_rfw;
			wb_rf_waddr <= ex_rf_waddr;
			wb_rf_wdata <= wb_data;
		end
	end

endmodule

// ==== hw/cpu_top.sv ====
/* five stage pipelined cpu */
`timescale 1ns/1ps

module cpu_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               imem_we,
	input  cpu_pkg::word_t     imem_addr,
	input  cpu_pkg::word_t     imem_wdata,
	input  cpu_pkg::word_t     dmem_dbg_addr,
	output cpu_pkg::word_t     dmem_dbg_rdata,
	output logic               wb_rfw,
	output cpu_pkg::reg_addr_t wb_rf_waddr,
	output cpu_pkg::word_t     wb_rf_wdata
);
	// fetch and redirect.
	cpu_pkg::word_t     if_pc;
	cpu_pkg::word_t     if_inst;
	logic               c_b;
	logic               c_j;
	cpu_pkg::word_t     baddr;
	cpu_pkg::word_t     jaddr;

	// id/ex.
	cpu_pkg::word_t     p_rfa;
	cpu_pkg::word_t     p_rfb;
	cpu_pkg::word_t     p_rfbse;
	cpu_pkg::shamt_t    p_shamt;
	cpu_pkg::func_t     p_func;
	cpu_pkg::opcode_t   p_alucontrol;
	cpu_pkg::reg_addr_t p_rf_waddr;
	cpu_pkg::word_t     p_jalra;
	logic               p_c_rfw;
	cpu_pkg::wb_sel_t   p_c_wbsource;
	logic               p_c_drw;

	// ex/mem.
	cpu_pkg::word_t     ex_result;
	cpu_pkg::word_t     ex_store_data;
	cpu_pkg::reg_addr_t ex_rf_waddr;
	cpu_pkg::word_t     ex_jalra;
	logic               ex_c_rfw;
	cpu_pkg::wb_sel_t   ex_c_wbsource;
	logic               ex_c_drw;

	cpu_fetch fetch_i (
		.clk, .rst, .imem_we, .imem_addr, .imem_wdata,
		.c_b, .baddr, .c_j, .jaddr, .if_pc, .if_inst
	);

	cpu_id id_i (
		.clk, .rst, .if_pc, .if_inst, .wb_rfw, .wb_rf_waddr, .wb_rf_wdata,
		.p_rfa, .p_rfb, .p_rfbse, .p_shamt, .p_func, .p_rf_waddr, .p_jalra,
		.p_c_rfw, .p_c_wbsource, .p_c_drw, .p_alucontrol,
		.c_b, .baddr, .c_j, .jaddr
	);

	cpu_ex ex_i (
		.clk, .rst, .p_rfa, .p_rfb, .p_rfbse, .p_shamt, .p_func, .p_alucontrol,
		.p_rf_waddr, .p_jalra, .p_c_rfw, .p_c_wbsource, .p_c_drw,
		.ex_result, .ex_store_data, .ex_rf_waddr, .ex_jalra,
		.ex_c_rfw, .ex_c_wbsource, .ex_c_drw
	);

	cpu_mem mem_i (
		.clk, .rst, .ex_result, .ex_store_data, .ex_jalra, .ex_rf_waddr,
		.ex_c_rfw, .ex_c_wbsource, .ex_c_drw, .dmem_dbg_addr, .dmem_dbg_rdata,
		.wb_rfw, .wb_rf_waddr, .wb_rf_wdata
	);

endmodule

// ==== verif/tb_clock.sv ====
/* testbench clock and reset */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// released on a falling edge.
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== verif/tb_cpu.sv ====
/* pipelined cpu testbench */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu;
	localparam int CLK_PERIOD_NS = 8;
	localparam int RUN_CYCLES    = 256;
	localparam int TEST_COUNT    = 6;
	localparam int TEST_CYCLES   = `CPU_IMEM_WORDS + RUN_CYCLES + 64; // load, run, reads.
	localparam int WATCHDOG_NS   = (TEST_COUNT * TEST_CYCLES + 100) * CLK_PERIOD_NS;

	logic               clk;
	logic               por_rst;
	logic               hold_rst;
	logic               rst;
	logic               imem_we;
	cpu_pkg::word_t     imem_addr;
	cpu_pkg::word_t     imem_wdata;
	cpu_pkg::word_t     dmem_dbg_addr;
	cpu_pkg::word_t     dmem_dbg_rdata;
	logic               wb_rfw;
	cpu_pkg::reg_addr_t wb_rf_waddr;
	cpu_pkg::word_t     wb_rf_wdata;

	cpu_pkg::word_t     prog[$];
	cpu_pkg::word_t     exp_addr[$];
	cpu_pkg::word_t     exp_data[$];
	cpu_pkg::reg_addr_t wb_exp_addr[$];
	cpu_pkg::word_t     wb_exp_data[$];
	cpu_pkg::reg_addr_t wb_seen_addr[$];
	cpu_pkg::word_t     wb_seen_data[$];
	cpu_pkg::word_t     next_addr = 32'h0; // next free result word.
	cpu_pkg::word_t     lfsr = 32'h1895;
	int                 checks = 0;
	int                 errors = 0;

	assign rst = por_rst | hold_rst;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) clock_i (.clk(clk), .rst(por_rst));

	cpu_top dut_i (
		.clk, .rst, .imem_we, .imem_addr, .imem_wdata, .dmem_dbg_addr, .dmem_dbg_rdata,
		.wb_rfw, .wb_rf_waddr, .wb_rf_wdata
	);

	always @(negedge clk) begin
		if (!rst && wb_rfw) begin
			wb_seen_addr.push_back(wb_rf_waddr);
			wb_seen_data.push_back(wb_rf_wdata);
		end
	end

	function automatic cpu_pkg::word_t r_type(input cpu_pkg::reg_addr_t rs,
		input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rd,
		input cpu_pkg::shamt_t sh, input cpu_pkg::func_t fn);
		return {cpu_pkg::op_rtype, rs, rt, rd, sh, fn};
	endfunction

	function automatic cpu_pkg::word_t i_type(input cpu_pkg::opcode_t op,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic cpu_pkg::word_t j_type(input cpu_pkg::opcode_t op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	// x^32 + x^22 + x^2 + x + 1.
	function automatic cpu_pkg::word_t next_rand();
		cpu_pkg::word_t w;
		logic           fb;
		w = '0;
		for (int k = 0; k < 32; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			w    = {w[30:0], fb};
		end
		return w;
	endfunction

	task automatic put(input cpu_pkg::word_t w);
		prog.push_back(w);
	endtask

	// three nops cover the writeback distance.
	task automatic emit(input cpu_pkg::word_t w);
		put(w);
		repeat (3) put(32'h0);
	endtask

	task automatic li(input cpu_pkg::reg_addr_t r, input cpu_pkg::word_t v);
		emit(i_type(cpu_pkg::op_lui, 5'd0, r, v[31:16]));
		emit(i_type(cpu_pkg::op_ori, r, r, v[15:0]));
	endtask

	task automatic store(input cpu_pkg::reg_addr_t rt, input cpu_pkg::word_t exp);
		put(i_type(cpu_pkg::op_sw, 5'd0, rt, next_addr[15:0]));
		exp_addr.push_back(next_addr);
		exp_data.push_back(exp);
		next_addr = next_addr + 32'd4;
	endtask

	task automatic expect_wb(input cpu_pkg::reg_addr_t r, input cpu_pkg::word_t d);
		wb_exp_addr.push_back(r);
		wb_exp_data.push_back(d);
	endtask

	task automatic alu_case(input cpu_pkg::word_t w, input cpu_pkg::word_t exp);
		emit(w);
		store(5'd10, exp);
	endtask

	task automatic start_prog();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		wb_exp_addr.delete();
		wb_exp_data.delete();
	endtask

	task automatic set_markers();
		emit(i_type(cpu_pkg::op_addiu, 5'd0, 5'd20, 16'h0bad)); // skipped path.
		emit(i_type(cpu_pkg::op_addiu, 5'd0, 5'd21, 16'h600d)); // executed path.
	endtask

	// branch or jump, delay slot store, then a store that is skipped when taken.
	// for jr and jalr, rs holds the target and rt is the link register.
	task automatic ctl_case(input cpu_pkg::opcode_t op, input cpu_pkg::func_t fn,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt, input logic taken);
		cpu_pkg::word_t mark;
		cpu_pkg::word_t pc;
		cpu_pkg::word_t ctl;
		if (op == cpu_pkg::op_rtype) begin
			emit(i_type(cpu_pkg::op_addiu, 5'd0, rs, 16'(prog.size() * 4 + 32)));
		end
		mark      = next_addr;
		next_addr = next_addr + 32'd4;
		put(i_type(cpu_pkg::op_sw, 5'd0, 5'd0, mark[15:0])); // clear marker.
		pc = 32'(prog.size() * 4);
		if (op == cpu_pkg::op_j || op == cpu_pkg::op_jal) begin
			ctl = j_type(op, 26'((pc + 32'd12) >> 2));
		end else if (op == cpu_pkg::op_rtype) begin
			ctl = r_type(rs, 5'd0, rt, 5'd0, fn);
		end else begin
			ctl = i_type(op, rs, rt, 16'd2);
		end
		put(ctl);
		if (op == cpu_pkg::op_jal) begin
			expect_wb(5'd31, pc + 32'd8);
		end else if (op == cpu_pkg::op_rtype && fn == cpu_pkg::fn_jalr) begin
			expect_wb(rt, pc + 32'd8);
		end
		store(5'd21, 32'h600d);
		put(i_type(cpu_pkg::op_sw, 5'd0, taken ? 5'd20 : 5'd21, mark[15:0]));
		exp_addr.push_back(mark);
		exp_data.push_back(taken ? 32'h0 : 32'h600d);
	endtask

	task automatic load_and_run();
		@(negedge clk);
		hold_rst = 1'b1;
		foreach (prog[i]) begin
			imem_we    = 1'b1;
			imem_addr  = 32'(i);
			imem_wdata = prog[i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		wb_seen_addr.delete();
		wb_seen_data.delete();
		hold_rst = 1'b0;
		repeat (RUN_CYCLES) @(negedge clk);
	endtask

	task automatic check_value(input string name, input cpu_pkg::word_t exp,
		input cpu_pkg::word_t got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, got);
		end
	endtask

	task automatic check_mem(input string name);
		foreach (exp_addr[i]) begin
			@(negedge clk);
			dmem_dbg_addr = exp_addr[i];
			#1;
			check_value($sformatf("%s @%h", name, exp_addr[i]), exp_data[i], dmem_dbg_rdata);
		end
	endtask

	task automatic check_wb(input string name);
		logic found;
		foreach (wb_exp_addr[i]) begin
			found = 1'b0;
			foreach (wb_seen_addr[k]) begin
				if (wb_seen_addr[k] == wb_exp_addr[i] && wb_seen_data[k] == wb_exp_data[i]) begin
					found = 1'b1;
				end
			end
			checks++;
			assert (found) else begin
				errors++;
				$display("%s: no writeback of %h to r%0d was seen", name, wb_exp_data[i],
					wb_exp_addr[i]);
			end
		end
	endtask

	task automatic finish_test(input string name);
		put(j_type(cpu_pkg::op_j, 26'(prog.size()))); // park on a self jump.
		put(32'h0);
		load_and_run();
		check_mem(name);
		check_wb(name);
	endtask

	task automatic test_alu();
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		a = 32'h8765_4321; // negative as signed.
		b = 32'h1234_5678;
		start_prog();
		li(5'd1, a);
		li(5'd2, b);
		alu_case(r_type(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::fn_addu), a + b);
		alu_case(r_type(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::fn_subu), a - b);
		alu_case(r_type(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::fn_and), a & b);
		alu_case(r_type(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::fn_or), a | b);
		alu_case(r_type(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::fn_xor), a ^ b);
		alu_case(r_type(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::fn_slt), {31'd0, $signed(a) < $signed(b)});
		alu_case(r_type(5'd2, 5'd1, 5'd10, 5'd0, cpu_pkg::fn_slt), {31'd0, $signed(b) < $signed(a)});
		alu_case(r_type(5'd0, 5'd2, 5'd10, 5'd4, cpu_pkg::fn_sll), b << 4);
		alu_case(r_type(5'd0, 5'd1, 5'd10, 5'd8, cpu_pkg::fn_srl), a >> 8);
		alu_case(i_type(cpu_pkg::op_addiu, 5'd2, 5'd10, 16'hfff0), b + 32'hffff_fff0);
		alu_case(i_type(cpu_pkg::op_slti, 5'd1, 5'd10, 16'h0010), {31'd0, $signed(a) < 16});
		alu_case(i_type(cpu_pkg::op_slti, 5'd2, 5'd10, 16'hfff0), {31'd0, $signed(b) < -16});
		alu_case(i_type(cpu_pkg::op_andi, 5'd1, 5'd10, 16'hf0f0), a & 32'h0000_f0f0);
		alu_case(i_type(cpu_pkg::op_ori, 5'd2, 5'd10, 16'h8001), b | 32'h0000_8001);
		alu_case(i_type(cpu_pkg::op_lui, 5'd0, 5'd10, 16'hbeef), 32'hbeef_0000);
		finish_test("alu");
	endtask

	task automatic test_reg_zero();
		start_prog();
		emit(i_type(cpu_pkg::op_addiu, 5'd0, 5'd10, 16'h0077));
		emit(i_type(cpu_pkg::op_addiu, 5'd0, 5'd0, 16'h0055));
		expect_wb(5'd0, 32'h55);
		put(i_type(cpu_pkg::op_sw, 5'd0, 5'd10, next_addr[15:0])); // nonzero first.
		store(5'd0, 32'h0);
		finish_test("reg_zero");
	endtask

	task automatic test_load_store();
		cpu_pkg::word_t a1;
		cpu_pkg::word_t a2;
		start_prog();
		li(5'd1, 32'hcafe_f00d);
		li(5'd2, 32'h0123_4567);
		a1 = next_addr;
		store(5'd1, 32'hcafe_f00d);
		a2 = next_addr;
		store(5'd2, 32'h0123_4567);
		emit(i_type(cpu_pkg::op_lw, 5'd0, 5'd13, a1[15:0]));
		emit(i_type(cpu_pkg::op_lw, 5'd0, 5'd14, a2[15:0]));
		store(5'd13, 32'hcafe_f00d);
		store(5'd14, 32'h0123_4567);
		expect_wb(5'd13, 32'hcafe_f00d);
		expect_wb(5'd14, 32'h0123_4567);
		finish_test("load_store");
	endtask

	task automatic test_branch();
		start_prog();
		set_markers();
		emit(i_type(cpu_pkg::op_addiu, 5'd0, 5'd1, 16'd5));
		emit(i_type(cpu_pkg::op_addiu, 5'd0, 5'd2, 16'd5));
		emit(i_type(cpu_pkg::op_addiu, 5'd0, 5'd3, 16'd7));
		ctl_case(cpu_pkg::op_beq, cpu_pkg::fn_sll, 5'd1, 5'd2, 1'b1);
		ctl_case(cpu_pkg::op_beq, cpu_pkg::fn_sll, 5'd1, 5'd3, 1'b0);
		ctl_case(cpu_pkg::op_bne, cpu_pkg::fn_sll, 5'd1, 5'd3, 1'b1);
		ctl_case(cpu_pkg::op_bne, cpu_pkg::fn_sll, 5'd1, 5'd2, 1'b0);
		finish_test("branch");
	endtask

	task automatic test_jump();
		start_prog();
		set_markers();
		ctl_case(cpu_pkg::op_j, cpu_pkg::fn_sll, 5'd0, 5'd0, 1'b1);
		ctl_case(cpu_pkg::op_jal, cpu_pkg::fn_sll, 5'd0, 5'd0, 1'b1);
		ctl_case(cpu_pkg::op_rtype, cpu_pkg::fn_jr, 5'd5, 5'd0, 1'b1);
		ctl_case(cpu_pkg::op_rtype, cpu_pkg::fn_jalr, 5'd6, 5'd7, 1'b1);
		finish_test("jump");
	endtask

	task automatic test_random();
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		start_prog();
		for (int i = 0; i < 10; i++) begin
			a = next_rand();
			b = next_rand();
			li(5'd1, a);
			li(5'd2, b);
			put(r_type(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::fn_addu));
			put(r_type(5'd1, 5'd2, 5'd11, 5'd0, cpu_pkg::fn_subu));
			put(r_type(5'd1, 5'd2, 5'd12, 5'd0, cpu_pkg::fn_xor));
			put(32'h0);
			store(5'd10, a + b);
			store(5'd11, a - b);
			store(5'd12, a ^ b);
		end
		finish_test("random");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	initial begin
		hold_rst      = 1'b0;
		imem_we       = 1'b0;
		imem_addr     = '0;
		imem_wdata    = '0;
		dmem_dbg_addr = '0;
		@(negedge clk);
		while (por_rst) begin
			@(negedge clk);
		end
		test_alu();
		test_reg_zero();
		test_load_store();
		test_branch();
		test_jump();
		test_random();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_fetch.sv
hw/cpu_id.sv
hw/cpu_ex.sv
hw/cpu_mem.sv
hw/cpu_top.sv
verif/tb_clock.sv
verif/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cpu testbench with verilator, run it and scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module tb_cpu -o tb_cpu_sim &&
./obj_dir/tb_cpu_sim > sim.log 2>&1 &&
cat sim.log &&
! grep -q "Checks failed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
